// ==== all.f ====
hdl/board_pkg.sv
hdl/psg_pkg.sv
hdl/cpu_bus_if.sv
hdl/bus_decoder.sv
hdl/work_ram.sv
hdl/psg.sv
hdl/sound_board.sv
bench/bench_clock.sv
bench/sound_board_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f all.f --top-module sound_board_tb -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "simulation ok" \
  || { echo "simulation failed or did not build"; exit 1; }

// ==== bench/sound_board_tb.sv ====
`timescale 1ns/1ps

module sound_board_tb;
  import board_pkg::*;
  import psg_pkg::*;

  localparam logic [31:0] seed = 32'h9bde_2d1f;
  localparam int ram_ops = 200;
  localparam int latch_ops = 30;
  localparam int unmapped_ops = 60;
  localparam int rom_ops = 30;
  localparam int vol_ops = 80;
  localparam int reset_timeout = 50;

  logic sample;
  logic reset;
  logic [adr_w-1:0] adr;
  logic [data_w-1:0] wdata;
  logic wr;
  logic rd;
  logic [data_w-1:0] code;
  logic code_load;
  logic [data_w-1:0] rdata;
  logic bus_error;
  logic [vol_w-1:0] psg0_a;
  logic [vol_w-1:0] psg0_b;
  logic [vol_w-1:0] psg0_c;
  logic [vol_w-1:0] psg1_a;
  logic [vol_w-1:0] psg1_b;
  logic [vol_w-1:0] psg1_c;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  logic [data_w-1:0] ram_model [ram_words];
  // reads only pick ram offsets that were written
  logic [ram_adr_w-1:0] ram_used [$];
  logic [data_w-1:0] latch_model;
  logic [idx_w-1:0] idx_model [2];
  // full 16-slot register file per psg
  logic [data_w-1:0] reg_model [2][16];

  int checks;
  int errors;
  int timeouts;
  logic reset_done;
  int wait_cnt;

  bench_clock clock_i (
    .sample(sample),
    .reset(reset)
  );

  sound_board dut_i (
    .sample(sample),
    .reset(reset),
    .adr(adr),
    .wdata(wdata),
    .wr(wr),
    .rd(rd),
    .code(code),
    .code_load(code_load),
    .rdata(rdata),
    .bus_error(bus_error),
    .psg0_a(psg0_a),
    .psg0_b(psg0_b),
    .psg0_c(psg0_c),
    .psg1_a(psg1_a),
    .psg1_b(psg1_b),
    .psg1_c(psg1_c)
  );

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // memory map as seen from the sound cpu
  function automatic logic is_mapped(input logic [adr_w-1:0] a);
    int ai;
    ai = int'(a);
    return ai < 'h4000 || (ai >= 'h4000 && ai <= 'h47ff) || ai == 'h6000 ||
      ai == 'h8000 || ai == 'h8001 || ai == 'hc000 || ai == 'hc001;
  endfunction

  function automatic logic [vol_w-1:0] dut_out(input int p, input int ch);
    case (p * 3 + ch)
      0: return psg0_a;
      1: return psg0_b;
      2: return psg0_c;
      3: return psg1_a;
      4: return psg1_b;
      default: return psg1_c;
    endcase
  endfunction

  function automatic logic [vol_w-1:0] model_vol(input int p, input int ch);
    return reg_model[p][reg_vol_a + ch][vol_w-1:0];
  endfunction

  ////////////////////////////////////////
  // bus cycles
  ////////////////////////////////////////

  // one-cycle write strobe with bus_error checked during and after it
  task automatic bus_write(input logic [adr_w-1:0] a, input logic [data_w-1:0] d);
    @(negedge sample);
    adr = a;
    wdata = d;
    wr = 1'b1;
    #1;
    check("bus_error on write", 32'(bus_error), 32'(!is_mapped(a)));
    @(negedge sample);
    wr = 1'b0;
    #1;
    check("bus_error idle", 32'(bus_error), 32'd0);
  endtask

  // rdata is valid one cycle after the strobe edge
  task automatic bus_read(input logic [adr_w-1:0] a, output logic [data_w-1:0] d);
    @(negedge sample);
    adr = a;
    rd = 1'b1;
    #1;
    check("bus_error on read", 32'(bus_error), 32'(!is_mapped(a)));
    @(negedge sample);
    rd = 1'b0;
    #1;
    check("bus_error idle", 32'(bus_error), 32'd0);
    @(negedge sample);
    d = rdata;
  endtask

  // model follows the register rules after the index and data writes
  task automatic psg_write(input int p, input logic [idx_w-1:0] idx, input logic [data_w-1:0] d);
    logic [adr_w-1:0] base;
    int i;
    base = (p == 1) ? psg1_base : psg0_base;
    bus_write(base, {4'h0, idx});
    idx_model[p] = idx;
    bus_write(base + 16'd1, d);
    i = int'(idx_model[p]);
    if (i <= 5) begin
      // odd registers keep only the high period nibble
      reg_model[p][i] = (i % 2 == 1) ? {4'h0, d[3:0]} : d;
    end else if (i == reg_mixer) begin
      reg_model[p][i] = d;
    end else if (i >= reg_vol_a && i <= reg_vol_a + 2) begin
      reg_model[p][i] = {4'h0, d[3:0]};
    end
  endtask

  ////////////////////////////////////////
  // test steps
  ////////////////////////////////////////

  task automatic test_reset();
    logic [data_w-1:0] d;
    for (int p = 0; p < 2; p++) begin
      for (int ch = 0; ch < 3; ch++) begin
        check($sformatf("reset psg%0d ch%0d", p, ch), 32'(dut_out(p, ch)), 32'd0);
      end
    end
    check("reset bus_error", 32'(bus_error), 32'd0);
    check("reset rdata", 32'(rdata), 32'd0);
    bus_read(latch_adr, d);
    check("reset latch", 32'(d), 32'd0);
  endtask

  task automatic test_ram();
    logic [ram_adr_w-1:0] off;
    logic [data_w-1:0] d;
    int k;
    for (int n = 0; n < ram_ops; n++) begin
      if (ram_used.size() == 0 || $urandom_range(1, 0) == 1) begin
        off = 11'($urandom);
        d = 8'($urandom);
        bus_write(ram_base | {5'b00000, off}, d);
        ram_model[off] = d;
        ram_used.push_back(off);
      end else begin
        k = int'($urandom_range(ram_used.size() - 1, 0));
        off = ram_used[k];
        bus_read(ram_base | {5'b00000, off}, d);
        check($sformatf("ram read %0h", off), 32'(d), 32'(ram_model[off]));
      end
    end
  endtask

  task automatic test_latch();
    logic [data_w-1:0] d;
    int loads;
    for (int n = 0; n < latch_ops; n++) begin
      // only the last of several loads counts
      loads = int'($urandom_range(3, 1));
      repeat (loads) begin
        @(negedge sample);
        code = 8'($urandom);
        code_load = 1'b1;
        latch_model = code;
        @(negedge sample);
        code_load = 1'b0;
      end
      bus_read(latch_adr, d);
      check("latch read", 32'(d), 32'(latch_model));
    end
  endtask

  task automatic test_bus_error();
    logic [adr_w-1:0] a;
    logic [data_w-1:0] d;
    for (int n = 0; n < unmapped_ops; n++) begin
      a = 16'($urandom);
      while (is_mapped(a)) a = 16'($urandom);
      if ($urandom_range(1, 0) == 1) begin
        bus_write(a, 8'($urandom));
      end else begin
        bus_read(a, d);
        check($sformatf("unmapped read %0h", a), 32'(d), 32'd0);
      end
    end
    // rom region decodes but returns zero
    for (int n = 0; n < rom_ops; n++) begin
      a = {2'b00, 14'($urandom)};
      bus_write(a, 8'($urandom));
      bus_read(a, d);
      check($sformatf("rom read %0h", a), 32'(d), 32'd0);
    end
    // generators are write-only
    bus_read(psg0_base, d);
    check("psg0 read", 32'(d), 32'd0);
    bus_read(psg1_base + 16'd1, d);
    check("psg1 read", 32'(d), 32'd0);
  endtask

  task automatic check_steady_outputs();
    for (int p = 0; p < 2; p++) begin
      for (int ch = 0; ch < 3; ch++) begin
        check($sformatf("volume psg%0d ch%0d", p, ch), 32'(dut_out(p, ch)),
          32'(model_vol(p, ch)));
      end
    end
  endtask

  task automatic test_volumes();
    int p;
    int ch;
    // with tones off the outputs follow the volume registers
    psg_write(0, 4'(reg_mixer), 8'h07);
    psg_write(1, 4'(reg_mixer), 8'h07);
    check_steady_outputs();
    for (int n = 0; n < vol_ops; n++) begin
      p = int'($urandom_range(1, 0));
      ch = int'($urandom_range(2, 0));
      psg_write(p, 4'(reg_vol_a + ch), 8'($urandom));
      check_steady_outputs();
    end
  endtask

  task automatic test_tone();
    int period [2][3];
    int limit [2][3];
    int done_at [2][3];
    logic seen_lo [2][3];
    logic seen_hi [2][3];
    int max_limit;
    int cycle;
    logic all_done;
    logic [vol_w-1:0] v;
    max_limit = 0;
    for (int p = 0; p < 2; p++) begin
      for (int ch = 0; ch < 3; ch++) begin
        period[p][ch] = int'($urandom_range(7, 0));
        limit[p][ch] = 2 * tone_prescale * (period[p][ch] + 1) + 10;
        if (limit[p][ch] > max_limit) max_limit = limit[p][ch];
        done_at[p][ch] = -1;
        seen_lo[p][ch] = 1'b0;
        seen_hi[p][ch] = 1'b0;
        psg_write(p, 4'(2 * ch), 8'(period[p][ch]));
        // junk in the upper nibble must not reach the period
        psg_write(p, 4'(2 * ch + 1), {4'($urandom), 4'h0});
        psg_write(p, 4'(reg_vol_a + ch), 8'($urandom_range(15, 1)));
      end
      psg_write(p, 4'(reg_mixer), {5'($urandom), 3'b000});
    end
    cycle = 0;
    all_done = 1'b0;
    while (!all_done && cycle < max_limit) begin
      @(negedge sample);
      cycle++;
      all_done = 1'b1;
      for (int p = 0; p < 2; p++) begin
        for (int ch = 0; ch < 3; ch++) begin
          v = dut_out(p, ch);
          if (v == 4'h0) begin
            seen_lo[p][ch] = 1'b1;
          end else begin
            check($sformatf("tone level psg%0d ch%0d", p, ch), 32'(v), 32'(model_vol(p, ch)));
            seen_hi[p][ch] = 1'b1;
          end
          if (seen_lo[p][ch] && seen_hi[p][ch] && done_at[p][ch] < 0) done_at[p][ch] = cycle;
          if (done_at[p][ch] < 0) all_done = 1'b0;
        end
      end
    end
    for (int p = 0; p < 2; p++) begin
      for (int ch = 0; ch < 3; ch++) begin
        if (done_at[p][ch] < 0 || done_at[p][ch] > limit[p][ch]) begin
          timeouts++;
          $display("psg%0d channel %0d did not toggle within %0d cycles", p, ch,
            limit[p][ch]);
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    adr = '0;
    wdata = '0;
    wr = 1'b0;
    rd = 1'b0;
    code = '0;
    code_load = 1'b0;
    checks = 0;
    errors = 0;
    timeouts = 0;
    latch_model = '0;
    for (int p = 0; p < 2; p++) begin
      idx_model[p] = '0;
      for (int i = 0; i < 16; i++) reg_model[p][i] = '0;
    end
    void'($urandom(seed));

    reset_done = 1'b0;
    wait_cnt = 0;
    while (!reset_done && wait_cnt < reset_timeout) begin
      @(negedge sample);
      // reset itself moves on the falling edge
      #1;
      if (!reset) reset_done = 1'b1;
      wait_cnt++;
    end

    if (!reset_done) begin
      timeouts++;
      $display("reset was never released");
    end else begin
      test_reset();
      test_ram();
      test_latch();
      test_bus_error();
      test_volumes();
      test_tone();
    end

    $display("summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== bench/bench_clock.sv ====
`timescale 1ns/1ps

module bench_clock (
  output logic sample,
  output logic reset
);

  // rising edges with reset held high
  localparam int reset_cycles = 4;

  // 20 ns sample clock
  initial begin
    sample = 1'b0;
    forever #10 sample = !sample;
  end

  // synchronous reset, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge sample);
    @(negedge sample);
    reset = 1'b0;
  end

endmodule

// ==== hdl/sound_board.sv ====
`timescale 1ns/1ps

module sound_board (
  input logic sample,
  input logic reset,
  input logic [board_pkg::adr_w-1:0] adr,
  input logic [board_pkg::data_w-1:0] wdata,
  input logic wr,
  input logic rd,
  input logic [board_pkg::data_w-1:0] code,
  input logic code_load,
  output logic [board_pkg::data_w-1:0] rdata,
  output logic bus_error,
  output logic [psg_pkg::vol_w-1:0] psg0_a,
  output logic [psg_pkg::vol_w-1:0] psg0_b,
  output logic [psg_pkg::vol_w-1:0] psg0_c,
  output logic [psg_pkg::vol_w-1:0] psg1_a,
  output logic [psg_pkg::vol_w-1:0] psg1_b,
  output logic [psg_pkg::vol_w-1:0] psg1_c
);

  ////////////////////////////////////////
  // per-target bus cycles
  ////////////////////////////////////////

  cpu_bus_if ram_bus ();
  cpu_bus_if psg0_bus ();
  cpu_bus_if psg1_bus ();

  // decoder also holds the sound-code latch
  bus_decoder bus_decoder_i (
    .sample(sample),
    .reset(reset),
    .adr(adr),
    .wdata(wdata),
    .wr(wr),
    .rd(rd),
    .code(code),
    .code_load(code_load),
    .rdata(rdata),
    .bus_error(bus_error),
    .ram_bus(ram_bus.source),
    .psg0_bus(psg0_bus.source),
    .psg1_bus(psg1_bus.source)
  );

  work_ram work_ram_i (
    .sample(sample),
    .bus(ram_bus.target)
  );

  ////////////////////////////////////////
  // sound generators
  ////////////////////////////////////////

  // 8000/8001
  psg psg0_i (
    .sample(sample),
    .reset(reset),
    .bus(psg0_bus.target),
    .tone_a(psg0_a),
    .tone_b(psg0_b),
    .tone_c(psg0_c)
  );

  // c000/c001
  psg psg1_i (
    .sample(sample),
    .reset(reset),
    .bus(psg1_bus.target),
    .tone_a(psg1_a),
    .tone_b(psg1_b),
    .tone_c(psg1_c)
  );

endmodule

// ==== hdl/psg.sv ====
`timescale 1ns/1ps

module psg (
  input logic sample,
  input logic reset,
  cpu_bus_if.target bus,
  output logic [psg_pkg::vol_w-1:0] tone_a,
  output logic [psg_pkg::vol_w-1:0] tone_b,
  output logic [psg_pkg::vol_w-1:0] tone_c
);
  import psg_pkg::*;

  logic wr_idx;
  logic wr_data;
  logic [idx_w-1:0] reg_idx;
  logic [1:0] vol_sel;
  logic [period_w-1:0] period [3];
  logic [period_w-1:0] eff_period [3];
  // mixer tone-disable, one bit per channel
  logic [2:0] tone_off;
  logic [vol_w-1:0] vol [3];
  logic [prescale_w-1:0] pre_cnt;
  logic pre_tick;
  logic [period_w-1:0] tone_cnt [3];
  logic [2:0] phase;
  logic [vol_w-1:0] chan_out [3];

  ////////////////////////////////////////
  // register access
  ////////////////////////////////////////

  // a0 low picks the register, a0 high writes it
  assign wr_idx = bus.sel && bus.wr && !bus.adr_lo[0];
  assign wr_data = bus.sel && bus.wr && bus.adr_lo[0];
  assign vol_sel = 2'(reg_idx - idx_w'(reg_vol_a));

  always_ff @(posedge sample) begin
    if (reset) begin
      reg_idx <= '0;
      tone_off <= '0;
      for (int i = 0; i < 3; i++) begin
        period[i] <= '0;
        vol[i] <= '0;
      end
    end else if (wr_idx) begin
      reg_idx <= bus.wdata[idx_w-1:0];
    end else if (wr_data) begin
      if (reg_idx <= idx_w'(reg_tone_last)) begin
        // channel is idx/2, odd idx is the high nibble
        if (reg_idx[0]) begin
          period[reg_idx[2:1]][period_w-1:8] <= bus.wdata[period_w-9:0];
        end else begin
          period[reg_idx[2:1]][7:0] <= bus.wdata;
        end
      end else if (reg_idx == idx_w'(reg_mixer)) begin
        // noise and i/o bits not fitted
        tone_off <= bus.wdata[2:0];
      end else if (reg_idx >= idx_w'(reg_vol_a) && reg_idx <= idx_w'(reg_vol_last)) begin
        vol[vol_sel] <= bus.wdata[vol_w-1:0];
      end
      // 6 and 11..15 dropped
    end
  end

  // write-only chip
  assign bus.rdata = '0;

  ////////////////////////////////////////
  // tone generation
  ////////////////////////////////////////

  // shared divider ahead of the three period counters
  assign pre_tick = pre_cnt == prescale_w'(tone_prescale - 1);

  // period 0 runs as 1
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      eff_period[i] = (period[i] == '0) ? period_w'(1) : period[i];
    end
  end

  always_ff @(posedge sample) begin
    if (reset) begin
      pre_cnt <= '0;
      phase <= '0;
      for (int i = 0; i < 3; i++) begin
        tone_cnt[i] <= '0;
      end
    end else begin
      pre_cnt <= pre_tick ? '0 : pre_cnt + 1'b1;
      if (pre_tick) begin
        for (int i = 0; i < 3; i++) begin
          // >= also catches a period shortened mid-count
          if ((period_w+1)'(tone_cnt[i]) + 1'b1 >= (period_w+1)'(eff_period[i])) begin
            tone_cnt[i] <= '0;
            phase[i] <= !phase[i];
          end else begin
            tone_cnt[i] <= tone_cnt[i] + 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // channel mixer
  ////////////////////////////////////////

  // disabled tone leaves a steady level at the volume
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      chan_out[i] = (tone_off[i] || phase[i]) ? vol[i] : '0;
    end
  end

  assign tone_a = chan_out[0];
  assign tone_b = chan_out[1];
  assign tone_c = chan_out[2];

  // index register keeps idx_w bits, a wider index would alias
  a_idx_range: assert property (@(posedge sample) disable iff (reset)
    wr_idx |-> bus.wdata < (1 << idx_w));

endmodule

// ==== hdl/work_ram.sv ====
`timescale 1ns/1ps

module work_ram (
  input logic sample,
  cpu_bus_if.target bus
);
  import board_pkg::*;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // z80 work area and stack
  logic [data_w-1:0] mem [ram_words];

  logic do_wr;
  logic do_rd;

  // only act on cycles decoded into this window
  assign do_wr = bus.sel && bus.wr;
  assign do_rd = bus.sel && bus.rd;

  ////////////////////////////////////////
  // access
  ////////////////////////////////////////

  // write lands at the sampling edge
  always_ff @(posedge sample) begin
    if (do_wr) begin
      mem[bus.adr_lo] <= bus.wdata;
    end
  end

  // read byte registered here, decoder picks it up next edge
  // holds until the next ram read
  always_ff @(posedge sample) begin
    if (do_rd) begin
      bus.rdata <= mem[bus.adr_lo];
    end
  end

  // strobes come from the cpu side through the decoder
  a_no_rd_wr: assert property (@(posedge sample) !(bus.rd && bus.wr));

endmodule

// ==== hdl/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder (
  input logic sample,
  input logic reset,
  input logic [board_pkg::adr_w-1:0] adr,
  input logic [board_pkg::data_w-1:0] wdata,
  input logic wr,
  input logic rd,
  input logic [board_pkg::data_w-1:0] code,
  input logic code_load,
  output logic [board_pkg::data_w-1:0] rdata,
  output logic bus_error,
  cpu_bus_if.source ram_bus,
  cpu_bus_if.source psg0_bus,
  cpu_bus_if.source psg1_bus
);
  import board_pkg::*;

  // where a pending read takes its data from
  typedef enum logic [2:0] {
    src_none,
    src_ram,
    src_latch,
    src_psg0,
    src_psg1
  } rd_src_t;

  logic rom_hit;
  logic ram_hit;
  logic latch_hit;
  logic psg0_hit;
  logic psg1_hit;
  logic mapped;
  logic [data_w-1:0] code_latch;
  logic rd_pend;
  rd_src_t rd_src;
  rd_src_t next_src;
  logic [data_w-1:0] read_mux;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  assign rom_hit = adr < rom_limit;
  // 2 KB window, compare above the ram word address
  assign ram_hit = adr[adr_w-1:ram_adr_w] == ram_base[adr_w-1:ram_adr_w];
  assign latch_hit = adr == latch_adr;
  // psg pairs ignore a0
  assign psg0_hit = adr[adr_w-1:1] == psg0_base[adr_w-1:1];
  assign psg1_hit = adr[adr_w-1:1] == psg1_base[adr_w-1:1];
  assign mapped = rom_hit || ram_hit || latch_hit || psg0_hit || psg1_hit;

  // only while a strobe is up
  assign bus_error = (wr || rd) && !mapped;

  // targets all see the same cycle, only sel differs
  assign ram_bus.sel = ram_hit;
  assign ram_bus.adr_lo = adr[ram_adr_w-1:0];
  assign ram_bus.wdata = wdata;
  assign ram_bus.wr = wr;
  assign ram_bus.rd = rd;

  assign psg0_bus.sel = psg0_hit;
  assign psg0_bus.adr_lo = adr[ram_adr_w-1:0];
  assign psg0_bus.wdata = wdata;
  assign psg0_bus.wr = wr;
  assign psg0_bus.rd = rd;

  assign psg1_bus.sel = psg1_hit;
  assign psg1_bus.adr_lo = adr[ram_adr_w-1:0];
  assign psg1_bus.wdata = wdata;
  assign psg1_bus.wr = wr;
  assign psg1_bus.rd = rd;

  ////////////////////////////////////////
  // read return
  ////////////////////////////////////////

  // rom region and unmapped space fall through to zero
  always_comb begin
    next_src = src_none;
    if (ram_hit) next_src = src_ram;
    else if (latch_hit) next_src = src_latch;
    else if (psg0_hit) next_src = src_psg0;
    else if (psg1_hit) next_src = src_psg1;
  end

  always_comb begin
    case (rd_src)
      src_ram: read_mux = ram_bus.rdata;
      src_latch: read_mux = code_latch;
      src_psg0: read_mux = psg0_bus.rdata;
      src_psg1: read_mux = psg1_bus.rdata;
      default: read_mux = '0;
    endcase
  end

  // edge n notes the source, edge n+1 takes the data
  // ram has registered its byte at edge n by then
  always_ff @(posedge sample) begin
    if (reset) begin
      code_latch <= '0;
      rd_pend <= 1'b0;
      rd_src <= src_none;
      rdata <= '0;
    end else begin
      if (code_load) code_latch <= code;
      rd_pend <= rd;
      if (rd) rd_src <= next_src;
      // held between reads
      if (rd_pend) rdata <= read_mux;
    end
  end

  // selects fan out to separate targets, two at once would fight
  a_one_sel: assert property (@(posedge sample) disable iff (reset)
    $onehot0({ram_bus.sel, latch_hit, psg0_bus.sel, psg1_bus.sel}));

endmodule

// ==== hdl/cpu_bus_if.sv ====
`timescale 1ns/1ps

// one decoded bus cycle, decoder to a single target
interface cpu_bus_if;
  import board_pkg::*;

  // high while the address falls in this target's window
  logic sel;
  // word address inside the window
  logic [ram_adr_w-1:0] adr_lo;
  logic [data_w-1:0] wdata;
  // one-cycle strobes, never both high
  logic wr;
  logic rd;
  // target read data, sampled by the decoder a cycle after rd
  logic [data_w-1:0] rdata;

  modport source (output sel, adr_lo, wdata, wr, rd, input rdata);

  modport target (input sel, adr_lo, wdata, wr, rd, output rdata);

endinterface

// ==== hdl/psg_pkg.sv ====
package psg_pkg;

  ////////////////////////////////////////
  // register file layout
  ////////////////////////////////////////

  // index register width, chip decodes 16 slots
  localparam int idx_w = 4;
  // tone periods in 0..5, low byte even, high nibble odd
  localparam int reg_tone_last = 5;
  // tone-disable bits 0..2 for channels a..c
  localparam int reg_mixer = 7;
  // volumes a..c in 8..10
  localparam int reg_vol_a = 8;
  localparam int reg_vol_last = 10;

  ////////////////////////////////////////
  // channel widths
  ////////////////////////////////////////

  localparam int period_w = 12;
  localparam int vol_w = 4;

  // sample clocks per tone counter step
  localparam int tone_prescale = 16;
  localparam int prescale_w = $clog2(tone_prescale);

endpackage

// ==== hdl/board_pkg.sv ====
package board_pkg;

  ////////////////////////////////////////
  // cpu bus widths
  ////////////////////////////////////////

  // sound cpu address bus
  localparam int adr_w = 16;
  // sound cpu data bus
  localparam int data_w = 8;

  ////////////////////////////////////////
  // memory map
  ////////////////////////////////////////

  // work ram, 2 KB at 4000-47ff
  localparam logic [adr_w-1:0] ram_base = 16'h4000;
  localparam int ram_words = 2048;
  // ram word address, also the low address carried to every target
  localparam int ram_adr_w = 11;

  // program rom sits below this address, not fitted here
  localparam logic [adr_w-1:0] rom_limit = 16'h4000;

  // sound code from the main board
  localparam logic [adr_w-1:0] latch_adr = 16'h6000;

  // psg pairs, even address = index, odd address = data
  localparam logic [adr_w-1:0] psg0_base = 16'h8000;
  localparam logic [adr_w-1:0] psg1_base = 16'hc000;

endpackage
